//--- hdl/armCtrlPkg.sv
package armCtrlPkg;

  // ==================
  // Instruction views
  // ==================

  // Data processing layout, bits 31..0
  typedef struct packed {
    logic [3:0]  cond;       // Condition field
    logic [1:0]  cls;        // Instruction class, bits 27:26
    logic        imm;        // I bit, immediate operand2
    logic [3:0]  opcode;     // ALU opcode, passed on as is
    logic        s;          // Set flags
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;   // Shifter operand, decoded in the datapath
  } dpFieldsT;

  // Word and unsigned byte load/store layout
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  cls;
    logic        imm;        // I bit, 0 selects the 12-bit immediate offset
    logic        pre;        // P, pre-index
    logic        up;         // U, add offset when set
    logic        byteSel;    // B, byte access
    logic        wback;      // W, base writeback
    logic        load;       // L, load when set
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } lsFieldsT;

  // One word, read as data processing or as load/store
  typedef union packed {
    dpFieldsT dpView;
    lsFieldsT lsView;
  } instrWordT;

  // ==================
  // Control bundles
  // ==================

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic       byteAccess;
    logic [1:0] flagWrite;   // [1] NZ, [0] CV
    logic [3:0] aluControl;
  } decodeCtrlT;

  // Driven by the hazard unit
  typedef struct packed {
    logic stallD, flushD;
    logic stallE, flushE;
    logic stallM, flushM;
    logic stallW, flushW;
  } hazardT;

  // Execute to memory to writeback
  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;
    logic [1:0] byteOffset;
  } memCtrlT;

  // Class codes, bits 27:26
  localparam logic [1:0] clsDataProc  = 2'b00;
  localparam logic [1:0] clsLoadStore = 2'b01;
  localparam logic [1:0] clsBranch    = 2'b10;

  localparam logic [3:0] aluAdd = 4'b0100;   // ADD opcode
  localparam logic [3:0] aluSub = 4'b0010;   // SUB opcode
  localparam logic [3:0] condAl = 4'b1110;   // Always
  localparam logic [3:0] regPc  = 4'd15;

endpackage

//--- hdl/memMask.sv
module memMask (
  input  logic       byteAccessE,
  input  logic [1:0] aluLowE,       // Low address bits from the ALU
  output logic [3:0] byteMaskE,
  output logic [1:0] byteOffsetE
);

  logic [3:0] laneSel;

  // One lane per byte address
  always_comb begin
    case (aluLowE)
      2'd0:    laneSel = 4'b0001;
      2'd1:    laneSel = 4'b0010;
      2'd2:    laneSel = 4'b0100;
      default: laneSel = 4'b1000;
    endcase
  end

  assign byteMaskE   = byteAccessE ? laneSel : 4'b1111;   // Word store writes all lanes
  assign byteOffsetE = aluLowE;                           // Load side byte select

endmodule

//--- hdl/condUnit.sv
module condUnit import armCtrlPkg::*; (
  input  logic [3:0] condE,
  input  flagsT      flagsE,       // Forwarded current flags
  input  flagsT      aluFlagsE,
  input  logic [1:0] flagWriteE,   // [1] NZ, [0] CV
  output logic       condExE,
  output logic       setFlagsE,
  output flagsT      flagsNextE
);

  logic n;
  logic z;
  logic c;
  logic v;
  logic ge;    // Signed greater or equal

  assign n  = flagsE.n;
  assign z  = flagsE.z;
  assign c  = flagsE.c;
  assign v  = flagsE.v;
  assign ge = (n == v);

  always_comb begin
    case (condE)
      4'b0000: condExE = z;                // EQ
      4'b0001: condExE = ~z;               // NE
      4'b0010: condExE = c;                // CS
      4'b0011: condExE = ~c;               // CC
      4'b0100: condExE = n;                // MI
      4'b0101: condExE = ~n;               // PL
      4'b0110: condExE = v;                // VS
      4'b0111: condExE = ~v;               // VC
      4'b1000: condExE = c & ~z;           // HI
      4'b1001: condExE = ~c | z;           // LS
      4'b1010: condExE = ge;               // GE
      4'b1011: condExE = ~ge;              // LT
      4'b1100: condExE = ~z & ge;          // GT
      4'b1101: condExE = z | ~ge;          // LE
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;             // 1111 never executes
    endcase
  end

  // NZ and CV halves update separately
  always_comb begin
    flagsNextE = flagsE;
    if (flagWriteE[1]) begin
      flagsNextE.n = aluFlagsE.n;
      flagsNextE.z = aluFlagsE.z;
    end
    if (flagWriteE[0]) begin
      flagsNextE.c = aluFlagsE.c;
      flagsNextE.v = aluFlagsE.v;
    end
  end

  assign setFlagsE = (|flagWriteE) & condExE;   // Failed condition leaves flags alone

endmodule

//--- hdl/flagsReg.sv
module flagsReg import armCtrlPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  stallW,
  input  logic  setFlagsM,
  input  flagsT flagsNextM,
  input  logic  setFlagsW,
  input  flagsT flagsNextW,
  output flagsT flagsE
);

  flagsT flagsQ;   // Architectural NZCV

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (setFlagsW && !stallW) begin
      flagsQ <= flagsNextW;          // Commit in writeback
    end
  end

  // Youngest pending writer wins
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsNextM;
    end else if (setFlagsW) begin
      flagsE = flagsNextW;
    end else begin
      flagsE = flagsQ;
    end
  end

endmodule

//--- hdl/decodeUnit.sv
module decodeUnit import armCtrlPkg::*; #(
  parameter int instrWidth = 32
) (
  input  logic       clk,
  input  logic       rstN,
  input  instrWordT  instrD,
  input  hazardT     hazard,
  output decodeCtrlT ctrlD,
  output logic       pcSrcD
);

  logic       validD;    // Low for the instruction behind a decode flush
  logic       arithOp;   // Opcode that produces C and V
  decodeCtrlT rawCtrl;   // Class decode before the valid gate

  if (instrWidth < $bits(instrWordT)) begin : gWidthCheck
    $error("decodeUnit: instrWidth %0d below instruction word", instrWidth);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validD <= 1'b0;
    end else if (hazard.flushD) begin
      validD <= 1'b0;                 // Kill strobes of the next decode word
    end else if (!hazard.stallD) begin
      validD <= 1'b1;
    end
  end

  // SUB RSB ADD ADC SBC RSC CMP CMN
  always_comb begin
    case (instrD.dpView.opcode)
      4'b0010, 4'b0011, 4'b0100, 4'b0101,
      4'b0110, 4'b0111, 4'b1010, 4'b1011: arithOp = 1'b1;
      default:                            arithOp = 1'b0;
    endcase
  end

  always_comb begin
    rawCtrl            = '0;
    rawCtrl.aluControl = aluAdd;      // Branch target is PC + offset
    case (instrD.dpView.cls)
      clsDataProc: begin
        rawCtrl.aluSrc     = instrD.dpView.imm;
        rawCtrl.regWrite   = 1'b1;
        rawCtrl.aluControl = instrD.dpView.opcode;
        rawCtrl.flagWrite  = {instrD.dpView.s, instrD.dpView.s & arithOp};
      end
      clsLoadStore: begin
        rawCtrl.regSrc     = {~instrD.lsView.load, 1'b0};  // Store data read from Rd
        rawCtrl.immSrc     = 2'b01;                        // 12-bit offset
        rawCtrl.aluSrc     = ~instrD.lsView.imm;
        rawCtrl.memtoReg   = instrD.lsView.load;
        rawCtrl.regWrite   = instrD.lsView.load;
        rawCtrl.memWrite   = ~instrD.lsView.load;
        rawCtrl.byteAccess = instrD.lsView.byteSel;
        rawCtrl.aluControl = instrD.lsView.up ? aluAdd : aluSub;
      end
      clsBranch: begin
        rawCtrl.regSrc = 2'b01;        // PC on first read port
        rawCtrl.immSrc = 2'b10;        // 24-bit branch offset
        rawCtrl.aluSrc = 1'b1;
        rawCtrl.branch = 1'b1;
      end
      default: begin
        rawCtrl.aluSrc = 1'b0;         // Coprocessor space, nothing decoded
      end
    endcase
  end

  // R15 destination or branch redirects the PC
  assign pcSrcD = validD & ((instrD.dpView.rd == regPc & rawCtrl.regWrite) | rawCtrl.branch);

  always_comb begin
    ctrlD           = rawCtrl;
    ctrlD.regWrite  = rawCtrl.regWrite & validD;
    ctrlD.memWrite  = rawCtrl.memWrite & validD;
    ctrlD.branch    = rawCtrl.branch & validD;
    ctrlD.flagWrite = rawCtrl.flagWrite & {2{validD}};
    ctrlD.pcSrc     = pcSrcD;
  end

endmodule

//--- hdl/stageControl.sv
module stageControl import armCtrlPkg::*; #(
  parameter int instrWidth = 32
) (
  input  logic        clk,
  input  logic        rstN,
  input  hazardT      hazard,
  input  decodeCtrlT  ctrlD,
  input  logic        pcSrcD,
  input  instrWordT   instrD,
  input  logic [31:0] aluResultE,
  // Condition check
  input  logic        condExE,
  input  flagsT       flagsNextE,
  input  logic        setFlagsE,
  output logic [3:0]  condE,
  output logic [1:0]  flagWriteE,
  // Byte lanes
  output logic        byteAccessE,
  output logic [1:0]  aluLowE,
  input  logic [3:0]  byteMaskE,
  input  logic [1:0]  byteOffsetE,
  // Datapath and flags
  output logic [3:0]  aluControlE,
  output logic        aluSrcE,
  output logic        branchTakenE,
  output memCtrlT     memM,
  output memCtrlT     memW,
  output logic        setFlagsM,
  output flagsT       flagsNextM,
  output logic        setFlagsW,
  output flagsT       flagsNextW,
  output logic        pcWrPending
);

  decodeCtrlT ctrlE;
  memCtrlT    memE;    // Gated bundle entering memory

  if (instrWidth < $bits(instrWordT)) begin : gWidthCheck
    $error("stageControl: instrWidth %0d below instruction word", instrWidth);
  end

  // ==================
  // Execute
  // ==================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE <= '0;
      condE <= '0;
    end else if (hazard.flushE) begin
      ctrlE <= '0;                              // Bubble
      condE <= '0;
    end else if (!hazard.stallE) begin
      ctrlE <= ctrlD;
      condE <= instrD.dpView.cond;
    end
  end

  assign aluControlE  = ctrlE.aluControl;
  assign aluSrcE      = ctrlE.aluSrc;
  assign flagWriteE   = ctrlE.flagWrite;
  assign byteAccessE  = ctrlE.byteAccess;
  assign aluLowE      = aluResultE[1:0];        // Byte address within the word
  assign branchTakenE = ctrlE.branch & condExE;

  always_comb begin
    memE.memWrite   = ctrlE.memWrite & condExE;
    memE.memtoReg   = ctrlE.memtoReg;
    memE.regWrite   = ctrlE.regWrite & condExE;
    memE.pcSrc      = ctrlE.pcSrc & condExE;
    memE.byteMask   = byteMaskE;
    memE.byteOffset = byteOffsetE;
  end

  // ==================
  // Memory, writeback
  // ==================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memM       <= '0;
      setFlagsM  <= 1'b0;
      flagsNextM <= '0;
    end else if (hazard.flushM) begin
      memM       <= '0;
      setFlagsM  <= 1'b0;
      flagsNextM <= '0;
    end else if (!hazard.stallM) begin
      memM       <= memE;
      setFlagsM  <= setFlagsE;
      flagsNextM <= flagsNextE;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memW       <= '0;
      setFlagsW  <= 1'b0;
      flagsNextW <= '0;
    end else if (hazard.flushW) begin
      memW       <= '0;
      setFlagsW  <= 1'b0;
      flagsNextW <= '0;
    end else if (!hazard.stallW) begin
      memW       <= memM;
      setFlagsW  <= setFlagsM;
      flagsNextW <= flagsNextM;
    end
  end

  assign pcWrPending = pcSrcD | ctrlE.pcSrc | memM.pcSrc;   // Fetch must hold

  // A store never loads back, whatever the class decode upstream
  aStoreNotLoad: assert property (@(posedge clk) disable iff (!rstN)
    memM.memWrite |-> !memM.memtoReg);

  // A taken branch always redirects the PC in memory next
  aBranchPc: assert property (@(posedge clk) disable iff (!rstN)
    branchTakenE && !hazard.stallM && !hazard.flushM |=> memM.pcSrc);

endmodule

//--- hdl/armController.sv
module armController import armCtrlPkg::*; #(
  parameter int instrWidth = 32
) (
  input  logic        clk,
  input  logic        rstN,
  input  instrWordT   instrD,
  input  hazardT      hazard,
  input  logic [31:0] aluResultE,
  input  flagsT       aluFlagsE,
  output logic [3:0]  aluControlE,
  output logic        aluSrcE,
  output logic        branchTakenE,
  output memCtrlT     memM,
  output memCtrlT     memW,
  output logic        pcWrPending,
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD
);

  decodeCtrlT ctrlD;
  logic       pcSrcD;
  logic [3:0] condE;
  logic [1:0] flagWriteE;
  logic       byteAccessE;
  logic [1:0] aluLowE;
  logic [3:0] byteMaskE;
  logic [1:0] byteOffsetE;
  logic       condExE;
  logic       setFlagsE;
  flagsT      flagsNextE;
  flagsT      flagsE;
  logic       setFlagsM;
  logic       setFlagsW;
  flagsT      flagsNextM;
  flagsT      flagsNextW;

  assign regSrcD = ctrlD.regSrc;   // Register file read selects
  assign immSrcD = ctrlD.immSrc;   // Extend unit select

  decodeUnit #(.instrWidth(instrWidth)) u_decodeUnit (
    .clk, .rstN, .instrD, .hazard, .ctrlD, .pcSrcD
  );

  stageControl #(.instrWidth(instrWidth)) u_stageControl (
    .clk, .rstN, .hazard, .ctrlD, .pcSrcD, .instrD, .aluResultE,
    .condExE, .flagsNextE, .setFlagsE, .condE, .flagWriteE,
    .byteAccessE, .aluLowE, .byteMaskE, .byteOffsetE,
    .aluControlE, .aluSrcE, .branchTakenE, .memM, .memW,
    .setFlagsM, .flagsNextM, .setFlagsW, .flagsNextW, .pcWrPending
  );

  condUnit u_condUnit (
    .condE, .flagsE, .aluFlagsE, .flagWriteE, .condExE, .setFlagsE, .flagsNextE
  );

  memMask u_memMask (.byteAccessE, .aluLowE, .byteMaskE, .byteOffsetE);

  flagsReg u_flagsReg (
    .clk, .rstN, .stallW(hazard.stallW), .setFlagsM, .flagsNextM,
    .setFlagsW, .flagsNextW, .flagsE
  );

endmodule

//--- verification/tbArmController.sv
module tbArmController import armCtrlPkg::*; ();

  localparam int dirCount   = 60;                           // Directed slots, upper bound
  localparam int randCount  = 150;
  localparam int cycleLimit = 20 * (dirCount + randCount) + 100;

  localparam hazardT noHazard  = 8'b0000_0000;
  localparam hazardT allStall  = 8'b1010_1010;              // stallD, stallE, stallM, stallW
  localparam hazardT execFlush = 8'b0001_0000;              // flushE only

  // Expected execute-stage contents
  typedef struct packed {
    logic [3:0] cond;
    logic [3:0] aluCtrl;
    logic [1:0] flagWrite;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       regWrite;
    logic       memtoReg;
    logic       memWrite;
    logic       pcSrc;
    logic       branch;
    logic       byteAccess;
  } refCtrlT;

  // Expected memory and writeback contents
  typedef struct packed {
    memCtrlT mem;
    logic    setFlags;
    flagsT   next;
  } refMemT;

  logic        clk = 1'b0;
  logic        rstN;
  instrWordT   instrD;
  hazardT      hazard;
  logic [31:0] aluResultE;
  flagsT       aluFlagsE;
  logic [3:0]  aluControlE;
  logic        aluSrcE;
  logic        branchTakenE;
  memCtrlT     memM;
  memCtrlT     memW;
  logic        pcWrPending;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;

  logic    validRef;     // Decode slot valid
  refCtrlT decRef;
  refCtrlT eRef;
  refMemT  nextM;
  refMemT  mRef;
  refMemT  wRef;
  flagsT   flagRef;      // Reference NZCV
  flagsT   fwdFlags;
  logic    condOk;
  logic    expPending;

  int cycles = 0;
  int errMemM = 0;
  int errMemW = 0;
  int errPend = 0;
  int errBranch = 0;
  int errAlu = 0;
  int errSel = 0;
  int errStall = 0;
  int errFlush = 0;
  int errMask = 0;

  armController #(.instrWidth(32)) u_armController (
    .clk, .rstN, .instrD, .hazard, .aluResultE, .aluFlagsE, .aluControlE, .aluSrcE,
    .branchTakenE, .memM, .memW, .pcWrPending, .regSrcD, .immSrcD
  );

  always #5 clk = ~clk;

  // ====================
  // Reference rules
  // ====================

  // ARM condition table, odd codes invert the even ones
  function automatic logic condHolds(input logic [3:0] cond, input flagsT f);
    logic r;
    case (cond[3:1])
      3'd0:    r = f.z;
      3'd1:    r = f.c;
      3'd2:    r = f.n;
      3'd3:    r = f.v;
      3'd4:    r = f.c & ~f.z;
      3'd5:    r = (f.n == f.v);
      3'd6:    r = ~f.z & (f.n == f.v);
      default: r = 1'b1;
    endcase
    return (cond == 4'hF) ? 1'b0 : (r ^ cond[0]);
  endfunction

  function automatic refCtrlT refDecode(input instrWordT w, input logic valid);
    refCtrlT c;
    logic    arith;
    c         = '0;
    c.cond    = w.dpView.cond;
    c.aluCtrl = aluAdd;                                     // Branch adds the offset
    arith     = w.dpView.opcode inside {[4'd2:4'd7], 4'd10, 4'd11};
    case (w.dpView.cls)
      clsDataProc: begin
        c.regWrite  = 1'b1;
        c.aluCtrl   = w.dpView.opcode;
        c.flagWrite = {w.dpView.s, w.dpView.s & arith};
        c.aluSrc    = w.dpView.imm;                         // I bit picks the immediate
      end
      clsLoadStore: begin
        c.regWrite   = w.lsView.load;
        c.memtoReg   = w.lsView.load;
        c.memWrite   = ~w.lsView.load;
        c.byteAccess = w.lsView.byteSel;
        c.aluCtrl    = w.lsView.up ? aluAdd : aluSub;
        c.regSrc     = w.lsView.load ? 2'b00 : 2'b10;       // Store data comes from Rd
        c.immSrc     = 2'b01;
        c.aluSrc     = !w.lsView.imm;                       // I clear means immediate offset
      end
      clsBranch: begin
        c.branch = 1'b1;
        c.regSrc = 2'b01;                                   // PC as base
        c.immSrc = 2'b10;
        c.aluSrc = 1'b1;
      end
      default:   c.branch = 1'b0;
    endcase
    c.pcSrc = c.branch | (c.regWrite & (w.dpView.rd == regPc));
    // Killed slot keeps its selects and loses every write
    c.regWrite  = c.regWrite & valid;
    c.memWrite  = c.memWrite & valid;
    c.branch    = c.branch & valid;
    c.pcSrc     = c.pcSrc & valid;
    c.flagWrite = c.flagWrite & {2{valid}};
    return c;
  endfunction

  assign decRef     = refDecode(instrD, validRef);
  assign fwdFlags   = mRef.setFlags ? mRef.next : (wRef.setFlags ? wRef.next : flagRef);
  assign condOk     = condHolds(eRef.cond, fwdFlags);
  assign expPending = decRef.pcSrc | eRef.pcSrc | mRef.mem.pcSrc;

  always_comb begin
    nextM.mem.memWrite   = eRef.memWrite & condOk;
    nextM.mem.memtoReg   = eRef.memtoReg;
    nextM.mem.regWrite   = eRef.regWrite & condOk;
    nextM.mem.pcSrc      = eRef.pcSrc & condOk;
    nextM.mem.byteMask   = eRef.byteAccess ? (4'b0001 << aluResultE[1:0]) : 4'b1111;
    nextM.mem.byteOffset = aluResultE[1:0];
    nextM.setFlags       = (|eRef.flagWrite) & condOk;
    nextM.next           = fwdFlags;
    if (eRef.flagWrite[1]) begin
      nextM.next.n = aluFlagsE.n;
      nextM.next.z = aluFlagsE.z;
    end
    if (eRef.flagWrite[0]) begin
      nextM.next.c = aluFlagsE.c;
      nextM.next.v = aluFlagsE.v;
    end
  end

  // Flush beats stall in every stage
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validRef <= 1'b0;
      eRef     <= '0;
      mRef     <= '0;
      wRef     <= '0;
      flagRef  <= '0;
    end else begin
      if (hazard.flushD)
        validRef <= 1'b0;
      else if (!hazard.stallD)
        validRef <= 1'b1;
      if (hazard.flushE)
        eRef <= '0;
      else if (!hazard.stallE)
        eRef <= decRef;
      if (hazard.flushM)
        mRef <= '0;
      else if (!hazard.stallM)
        mRef <= nextM;
      if (hazard.flushW)
        wRef <= '0;
      else if (!hazard.stallW)
        wRef <= mRef;
      if (wRef.setFlags && !hazard.stallW)
        flagRef <= wRef.next;                               // Commit in writeback
    end
  end

  // ====================
  // Checks
  // ====================
  chkMemM: assert property (@(posedge clk) disable iff (!rstN) memM == mRef.mem)
    else begin
      errMemM++;
      $display("ERR %0t: memM %h expected %h", $time, $sampled(memM), $sampled(mRef.mem));
    end

  chkMemW: assert property (@(posedge clk) disable iff (!rstN) memW == wRef.mem)
    else begin
      errMemW++;
      $display("ERR %0t: memW %h expected %h", $time, $sampled(memW), $sampled(wRef.mem));
    end

  chkPend: assert property (@(posedge clk) disable iff (!rstN) pcWrPending == expPending)
    else begin
      errPend++;
      $display("ERR %0t: pcWrPending %b expected %b", $time, $sampled(pcWrPending),
               $sampled(expPending));
    end

  chkBranch: assert property (@(posedge clk) disable iff (!rstN)
    branchTakenE == (eRef.branch & condOk))
    else begin
      errBranch++;
      $display("ERR %0t: branchTakenE %b disagrees with condition", $time,
               $sampled(branchTakenE));
    end

  chkAlu: assert property (@(posedge clk) disable iff (!rstN) aluControlE == eRef.aluCtrl)
    else begin
      errAlu++;
      $display("ERR %0t: aluControlE %h expected %h", $time, $sampled(aluControlE),
               $sampled(eRef.aluCtrl));
    end

  // Register, extend and ALU operand selects
  chkSel: assert property (@(posedge clk) disable iff (!rstN)
    regSrcD == decRef.regSrc && immSrcD == decRef.immSrc && aluSrcE == eRef.aluSrc)
    else begin
      errSel++;
      $display("ERR %0t: regSrcD %b immSrcD %b aluSrcE %b expected %b %b %b", $time,
               $sampled(regSrcD), $sampled(immSrcD), $sampled(aluSrcE),
               $sampled(decRef.regSrc), $sampled(decRef.immSrc), $sampled(eRef.aluSrc));
    end

  chkStall: assert property (@(posedge clk) disable iff (!rstN)
    hazard == allStall |=> $stable(memM) && $stable(memW))
    else begin
      errStall++;
      $display("ERR %0t: memM or memW moved during a full stall", $time);
    end

  // Bubble reaches memory two edges on and writeback one after
  chkFlush: assert property (@(posedge clk) disable iff (!rstN)
    hazard.flushE && !hazard.stallE |-> ##2 (!memM.memWrite && !memM.regWrite)
    ##1 (!memW.memWrite && !memW.regWrite))
    else begin
      errFlush++;
      $display("ERR %0t: flushed instruction raised a write strobe", $time);
    end

  chkMask: assert property (@(posedge clk) disable iff (!rstN)
    memM.memWrite |-> (memM.byteMask == 4'hF) ||
    ($onehot(memM.byteMask) && memM.byteMask[memM.byteOffset]))
    else begin
      errMask++;
      $display("ERR %0t: store byteMask %b at offset %0d", $time, $sampled(memM.byteMask),
               $sampled(memM.byteOffset));
    end

  // ====================
  // Stimulus
  // ====================
  function automatic instrWordT dpWord(input logic [3:0] cond, input logic [3:0] op,
                                       input logic s, input logic [3:0] rd);
    return {cond, clsDataProc, 1'b0, op, s, 4'd1, rd, 12'h002};
  endfunction

  // Pre-indexed word or byte access, base r2, data r3
  function automatic instrWordT lsWord(input logic [3:0] cond, input logic load,
                                       input logic byteSel, input logic up);
    return {cond, clsLoadStore, 1'b0, 1'b1, up, byteSel, 1'b0, load, 4'd2, 4'd3, 12'h004};
  endfunction

  function automatic instrWordT brWord(input logic [3:0] cond);
    return {cond, clsBranch, 26'h000_0010};
  endfunction

  function automatic instrWordT randWord();
    logic [31:0] r;
    int          cls;
    r        = $urandom;
    cls      = $urandom_range(2, 0);
    r[27:26] = cls[1:0];                                    // Decoded classes only
    if ($urandom_range(1, 0) == 0) begin
      r[31:28] = condAl;
    end
    return r;
  endfunction

  function automatic hazardT randHazard();
    hazardT h;
    h        = noHazard;
    h.flushD = ($urandom_range(7, 0) == 0);
    h.flushE = ($urandom_range(7, 0) == 0);
    return h;
  endfunction

  task automatic issue(input instrWordT w, input hazardT h);
    @(posedge clk);
    #1;
    instrD     = w;
    hazard     = h;
    aluResultE = $urandom;                                  // Random byte lane
  endtask

  task automatic idle(input int n);
    repeat (n) issue(dpWord(4'hF, 4'b1101, 1'b0, 4'd0), noHazard);   // Never-executed MOV
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    int totalErr;
    void'($urandom(32'ha2df_467f));
    rstN       = 1'b0;
    instrD     = dpWord(4'hF, 4'b1101, 1'b0, 4'd0);
    hazard     = noHazard;
    aluResultE = '0;
    aluFlagsE  = '0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    idle(2);

    // Always-executed mix of all classes
    issue(dpWord(condAl, aluAdd, 1'b0, 4'd1), noHazard);
    issue(lsWord(condAl, 1'b1, 1'b0, 1'b1), noHazard);      // LDR
    issue(lsWord(condAl, 1'b0, 1'b0, 1'b0), noHazard);      // STR, down
    issue(lsWord(condAl, 1'b0, 1'b1, 1'b1), noHazard);      // STRB
    issue(brWord(condAl), noHazard);
    issue(dpWord(condAl, 4'b1101, 1'b0, regPc), noHazard);  // MOV pc
    issue(dpWord(condAl, aluSub, 1'b1, 4'd4), noHazard);    // SUBS
    idle(3);

    // Compare then conditional stores, Z set
    aluFlagsE = 4'b0100;
    issue(dpWord(condAl, 4'b1010, 1'b1, 4'd0), noHazard);
    issue(lsWord(4'b0000, 1'b0, 1'b0, 1'b1), noHazard);     // EQ
    issue(lsWord(4'b0001, 1'b0, 1'b0, 1'b1), noHazard);     // NE
    issue(lsWord(4'b1010, 1'b0, 1'b1, 1'b1), noHazard);     // GE
    issue(lsWord(4'b1011, 1'b0, 1'b0, 1'b1), noHazard);     // LT
    // N set this time
    aluFlagsE = 4'b1000;
    issue(dpWord(condAl, 4'b1010, 1'b1, 4'd0), noHazard);
    issue(lsWord(4'b0100, 1'b0, 1'b0, 1'b1), noHazard);     // MI
    issue(lsWord(4'b0101, 1'b0, 1'b0, 1'b1), noHazard);     // PL
    issue(lsWord(4'b1011, 1'b0, 1'b1, 1'b1), noHazard);     // LT
    issue(lsWord(4'b1100, 1'b0, 1'b0, 1'b1), noHazard);     // GT
    idle(3);

    repeat (4) issue(lsWord(condAl, 1'b0, 1'b1, 1'b1), noHazard);   // Byte lanes

    // Execute flush
    issue(lsWord(condAl, 1'b0, 1'b0, 1'b1), execFlush);
    issue(dpWord(condAl, aluAdd, 1'b0, 4'd5), execFlush);
    idle(3);

    // Full stall with the pipe loaded
    issue(lsWord(condAl, 1'b0, 1'b0, 1'b1), noHazard);
    issue(lsWord(condAl, 1'b1, 1'b0, 1'b1), noHazard);
    issue(brWord(condAl), noHazard);
    repeat (3) issue(brWord(condAl), allStall);
    idle(4);

    repeat (randCount) begin
      aluFlagsE = flagsT'($urandom_range(15, 0));
      issue(randWord(), randHazard());
    end
    idle(4);

    totalErr = errMemM + errMemW + errPend + errBranch + errAlu + errSel + errStall
             + errFlush + errMask;
    $write("Errors: memM %0d memW %0d pend %0d branch %0d alu %0d sel %0d",
           errMemM, errMemW, errPend, errBranch, errAlu, errSel);
    $display(" stall %0d flush %0d mask %0d", errStall, errFlush, errMask);
    if (totalErr == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/armCtrlPkg.sv
hdl/memMask.sv
hdl/condUnit.sv
hdl/flagsReg.sv
hdl/decodeUnit.sv
hdl/stageControl.sv
hdl/armController.sv
verification/tbArmController.sv
